//--- phy_rx_params.svh
`ifndef PHY_RX_PARAMS_SVH
`define PHY_RX_PARAMS_SVH

// symbol stream geometry
`define PHY_RX_DATA_W 32
`define PHY_RX_BYTES 4

// 8b/10b framing K-codes
`define PHY_RX_STP 8'hFB
`define PHY_RX_SDP 8'h5C
`define PHY_RX_END 8'hFD

// axi-stream user field, one-hot packet kind
`define PHY_RX_USER_W 2
`define PHY_RX_USER_DLLP 2'b01
`define PHY_RX_USER_TLP 2'b10

`endif

//--- phy_rx_pkg.sv
`default_nettype none

`include "phy_rx_params.svh"

package phy_rx_pkg;

  // kind of frame, taken from the start symbol
  typedef enum logic {
    PKT_DLLP = 1'b0,
    PKT_TLP  = 1'b1
  } pkt_kind_e;

  // one word as read from the phy fifo
  typedef struct packed {
    logic [`PHY_RX_DATA_W-1:0] data;
    logic [`PHY_RX_BYTES-1:0]  k;
  } sym_word_t;

  // word after framing, byte_en marks payload bytes
  typedef struct packed {
    logic [`PHY_RX_DATA_W-1:0] data;
    logic [`PHY_RX_BYTES-1:0]  byte_en;
    logic                      sof;
    logic                      eof;
    pkt_kind_e                 kind;
  } framed_word_t;

  // one axi-stream beat
  typedef struct packed {
    logic [`PHY_RX_DATA_W-1:0] tdata;
    logic [`PHY_RX_BYTES-1:0]  tkeep;
    logic                      tlast;
    logic [`PHY_RX_USER_W-1:0] tuser;
  } axis_beat_t;

endpackage

`default_nettype wire

//--- rx_word_capture.sv
`timescale 1ns/1ps
`default_nettype none

module rx_word_capture (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  phy_link_up_i,
  input  logic                  phy_fifo_empty_i,
  output logic                  phy_fifo_rd_en_o,
  input  phy_rx_pkg::sym_word_t sym_i,
  output phy_rx_pkg::sym_word_t word_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  phy_rx_pkg::sym_word_t word_q;
  logic                  valid_q;
  // set one cycle after reset, so a pop always lands in a live register
  logic                  run_q;

  // fifo is first-word-fall-through, the head is on sym_i while not empty
  assign phy_fifo_rd_en_o = run_q && phy_link_up_i && !phy_fifo_empty_i &&
                            (!valid_q || ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (phy_fifo_rd_en_o) begin
        valid_q <= 1'b1;
      end else if (ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (phy_fifo_rd_en_o) begin
      word_q <= sym_i;
    end
  end

  assign word_o  = word_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

//--- frame_detector.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_rx_params.svh"

module frame_detector (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  phy_rx_pkg::sym_word_t    word_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output phy_rx_pkg::framed_word_t fword_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  phy_rx_pkg::framed_word_t fword_q;
  phy_rx_pkg::framed_word_t fword_n;
  phy_rx_pkg::pkt_kind_e    kind_q;
  logic                     valid_q;
  logic                     in_frame_q;
  logic                     out_valid_n;
  logic                     in_frame_n;
  logic [`PHY_RX_BYTES-1:0] is_start;
  logic [`PHY_RX_BYTES-1:0] is_end;
  logic                     accept;

  assign ready_o = !valid_q || ready_i;
  assign accept  = valid_i && ready_o;

  always_comb begin
    for (int b = 0; b < `PHY_RX_BYTES; b++) begin
      is_start[b] = word_i.k[b] && (word_i.data[8*b +: 8] == `PHY_RX_STP ||
                                    word_i.data[8*b +: 8] == `PHY_RX_SDP);
      is_end[b]   = word_i.k[b] && (word_i.data[8*b +: 8] == `PHY_RX_END);
    end
  end

  always_comb begin : detect
    logic start_found;
    logic end_found;
    int   start_pos;
    int   end_pos;
    start_found  = 1'b0;
    end_found    = 1'b0;
    start_pos    = 0;
    end_pos      = 0;
    fword_n      = '0;
    fword_n.data = word_i.data;
    fword_n.kind = kind_q;
    // lowest start symbol wins
    if (!in_frame_q) begin
      for (int b = `PHY_RX_BYTES - 1; b >= 0; b--) begin
        if (is_start[b]) begin
          start_found = 1'b1;
          start_pos   = b;
        end
      end
      if (start_found) begin
        fword_n.kind = (word_i.data[8*start_pos +: 8] == `PHY_RX_STP) ?
                       phy_rx_pkg::PKT_TLP : phy_rx_pkg::PKT_DLLP;
      end
    end
    // END only counts after the start, or anywhere once inside a frame
    for (int b = `PHY_RX_BYTES - 1; b >= 0; b--) begin
      if (is_end[b] && (in_frame_q || (start_found && b > start_pos))) begin
        end_found = 1'b1;
        end_pos   = b;
      end
    end
    for (int b = 0; b < `PHY_RX_BYTES; b++) begin
      fword_n.byte_en[b] = (in_frame_q || (start_found && b > start_pos)) &&
                           (!end_found || b < end_pos);
    end
    fword_n.sof = start_found;
    fword_n.eof = end_found;
    out_valid_n = in_frame_q || start_found;
    in_frame_n  = out_valid_n && !end_found;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q    <= 1'b0;
      in_frame_q <= 1'b0;
    end else if (accept) begin
      // idle words are consumed without output
      valid_q    <= out_valid_n;
      in_frame_q <= in_frame_n;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      fword_q <= fword_n;
      kind_q  <= fword_n.kind;
    end
  end

  assign fword_o = fword_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

//--- byte_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_rx_params.svh"

module byte_packer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  phy_rx_pkg::framed_word_t fword_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output phy_rx_pkg::axis_beat_t   beat_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  // contiguous low keep bits for a byte count of 0 to 4
  function automatic logic [`PHY_RX_BYTES-1:0] keep_mask(input logic [3:0] cnt);
    logic [`PHY_RX_BYTES:0] m;
    m = (5'd1 << cnt) - 5'd1;
    return m[`PHY_RX_BYTES-1:0];
  endfunction

  function automatic logic [`PHY_RX_USER_W-1:0] kind_user(input phy_rx_pkg::pkt_kind_e k);
    return (k == phy_rx_pkg::PKT_TLP) ? `PHY_RX_USER_TLP : `PHY_RX_USER_DLLP;
  endfunction

  phy_rx_pkg::axis_beat_t    beat_q;
  phy_rx_pkg::axis_beat_t    beat_n;
  phy_rx_pkg::pkt_kind_e     kind_q;
  logic                      valid_q;
  // held bytes, never more than one beat between words
  logic [`PHY_RX_DATA_W-1:0] acc_q;
  logic [`PHY_RX_DATA_W-1:0] acc_n;
  logic [2:0]                cnt_q;
  logic [2:0]                cnt_n;
  // second beat of an end-of-frame flush still owed
  logic                      pend_q;
  logic                      pend_n;
  logic                      load;
  logic                      out_free;
  logic                      accept;

  assign out_free = !valid_q || ready_i;
  assign ready_o  = out_free && !pend_q;
  assign accept   = valid_i && ready_o;

  always_comb begin : pack
    logic [`PHY_RX_DATA_W-1:0]   compact;
    logic [`PHY_RX_DATA_W-1:0]   base_acc;
    logic [2*`PHY_RX_DATA_W-1:0] merged;
    logic [2:0]                  n_bytes;
    logic [2:0]                  base_cnt;
    logic [3:0]                  total;
    logic [3:0]                  rem;
    compact = '0;
    n_bytes = '0;
    // squeeze out the non-payload bytes, earliest byte lowest
    for (int b = 0; b < `PHY_RX_BYTES; b++) begin
      if (fword_i.byte_en[b]) begin
        compact[8*n_bytes +: 8] = fword_i.data[8*b +: 8];
        n_bytes = n_bytes + 3'd1;
      end
    end
    base_acc = fword_i.sof ? '0 : acc_q;
    base_cnt = fword_i.sof ? 3'd0 : cnt_q;
    merged   = {{`PHY_RX_DATA_W{1'b0}}, base_acc} |
               ({{`PHY_RX_DATA_W{1'b0}}, compact} << (8 * base_cnt));
    total    = {1'b0, base_cnt} + {1'b0, n_bytes};
    rem      = total - 4'd4;
    load     = 1'b0;
    beat_n   = beat_q;
    acc_n    = acc_q;
    cnt_n    = cnt_q;
    pend_n   = pend_q;
    if (pend_q) begin
      if (out_free) begin
        load         = 1'b1;
        beat_n.tdata = acc_q;
        beat_n.tkeep = keep_mask({1'b0, cnt_q});
        beat_n.tlast = 1'b1;
        beat_n.tuser = kind_user(kind_q);
        cnt_n        = '0;
        pend_n       = 1'b0;
      end
    end else if (accept) begin
      beat_n.tdata = merged[`PHY_RX_DATA_W-1:0];
      beat_n.tuser = kind_user(fword_i.kind);
      if (fword_i.eof && total <= 4'd4) begin
        load         = (total != 4'd0);
        beat_n.tkeep = keep_mask(total);
        beat_n.tlast = 1'b1;
        cnt_n        = '0;
      end else if (total > 4'd4) begin
        // a full beat goes out only when more bytes follow it
        load         = 1'b1;
        beat_n.tkeep = '1;
        beat_n.tlast = 1'b0;
        acc_n        = merged[2*`PHY_RX_DATA_W-1:`PHY_RX_DATA_W];
        cnt_n        = rem[2:0];
        pend_n       = fword_i.eof;
      end else begin
        acc_n = merged[`PHY_RX_DATA_W-1:0];
        cnt_n = total[2:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
      pend_q  <= 1'b0;
    end else begin
      cnt_q  <= cnt_n;
      pend_q <= pend_n;
      if (load) begin
        valid_q <= 1'b1;
      end else if (ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_n;
    if (load) begin
      beat_q <= beat_n;
    end
    if (accept) begin
      kind_q <= fword_i.kind;
    end
  end

  assign beat_o  = beat_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

//--- axis_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  phy_rx_pkg::axis_beat_t beat_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  output phy_rx_pkg::axis_beat_t beat_o,
  output logic                   valid_o,
  input  logic                   ready_i
);

  phy_rx_pkg::axis_beat_t out_q;
  phy_rx_pkg::axis_beat_t skid_q;
  logic                   out_valid_q;
  logic                   skid_valid_q;
  logic                   out_free;
  logic                   in_xfer;

  // ready comes straight from a flop, no path from ready_i
  assign ready_o  = !skid_valid_q;
  assign out_free = !out_valid_q || ready_i;
  assign in_xfer  = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      // skid entry drains first to keep order
      if (skid_valid_q) begin
        out_valid_q  <= 1'b1;
        skid_valid_q <= 1'b0;
      end else begin
        out_valid_q <= in_xfer;
      end
    end else if (in_xfer) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      if (skid_valid_q) begin
        out_q <= skid_q;
      end else if (in_xfer) begin
        out_q <= beat_i;
      end
    end else if (in_xfer) begin
      skid_q <= beat_i;
    end
  end

  assign beat_o  = out_q;
  assign valid_o = out_valid_q;

endmodule

`default_nettype wire

//--- phy_rx_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_rx_params.svh"

module phy_rx_framer (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      phy_link_up_i,
  input  logic                      phy_fifo_empty_i,
  output logic                      phy_fifo_rd_en_o,
  input  logic [`PHY_RX_DATA_W-1:0] phy_data_i,
  input  logic [`PHY_RX_BYTES-1:0]  phy_k_i,
  output logic [`PHY_RX_DATA_W-1:0] m_axis_tdata_o,
  output logic [`PHY_RX_BYTES-1:0]  m_axis_tkeep_o,
  output logic                      m_axis_tvalid_o,
  output logic                      m_axis_tlast_o,
  output logic [`PHY_RX_USER_W-1:0] m_axis_tuser_o,
  input  logic                      m_axis_tready_i
);

  phy_rx_pkg::sym_word_t    sym;
  phy_rx_pkg::sym_word_t    cap_word;
  phy_rx_pkg::framed_word_t det_word;
  phy_rx_pkg::axis_beat_t   pack_beat;
  phy_rx_pkg::axis_beat_t   out_beat;
  logic                     cap_valid;
  logic                     det_ready;
  logic                     det_valid;
  logic                     pack_ready;
  logic                     pack_valid;
  logic                     skid_ready;

  assign sym.data = phy_data_i;
  assign sym.k    = phy_k_i;

  rx_word_capture u_capture (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .phy_link_up_i    (phy_link_up_i),
    .phy_fifo_empty_i (phy_fifo_empty_i),
    .phy_fifo_rd_en_o (phy_fifo_rd_en_o),
    .sym_i            (sym),
    .word_o           (cap_word),
    .valid_o          (cap_valid),
    .ready_i          (det_ready)
  );

  frame_detector u_detector (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .word_i  (cap_word),
    .valid_i (cap_valid),
    .ready_o (det_ready),
    .fword_o (det_word),
    .valid_o (det_valid),
    .ready_i (pack_ready)
  );

  byte_packer u_packer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .fword_i (det_word),
    .valid_i (det_valid),
    .ready_o (pack_ready),
    .beat_o  (pack_beat),
    .valid_o (pack_valid),
    .ready_i (skid_ready)
  );

  axis_skid_buffer u_skid (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .beat_i  (pack_beat),
    .valid_i (pack_valid),
    .ready_o (skid_ready),
    .beat_o  (out_beat),
    .valid_o (m_axis_tvalid_o),
    .ready_i (m_axis_tready_i)
  );

  assign m_axis_tdata_o = out_beat.tdata;
  assign m_axis_tkeep_o = out_beat.tkeep;
  assign m_axis_tlast_o = out_beat.tlast;
  assign m_axis_tuser_o = out_beat.tuser;

endmodule

`default_nettype wire

//--- phy_rx_framer_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_rx_params.svh"

module phy_rx_framer_assert (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      link_up_i,
  input logic                      fifo_empty_i,
  input logic                      rd_en_i,
  input logic [`PHY_RX_DATA_W-1:0] tdata_i,
  input logic [`PHY_RX_BYTES-1:0]  tkeep_i,
  input logic                      tvalid_i,
  input logic                      tlast_i,
  input logic [`PHY_RX_USER_W-1:0] tuser_i,
  input logic                      tready_i
);

  a_read_allowed: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_en_i |-> link_up_i && !fifo_empty_i)
    else $error("fifo read while link down or fifo empty");

  // a stalled beat holds until taken
  a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    tvalid_i && !tready_i |=> tvalid_i && $stable({tdata_i, tkeep_i, tlast_i, tuser_i}))
    else $error("output beat changed while stalled");

  a_keep_shape: assert property (@(posedge clk_i) disable iff (rst_i)
    tvalid_i |-> tkeep_i == 4'b1111 ||
      (tlast_i && (tkeep_i == 4'b0001 || tkeep_i == 4'b0011 || tkeep_i == 4'b0111)))
    else $error("tkeep not contiguous from bit 0 or partial without tlast");

  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> !tvalid_i && !rd_en_i)
    else $error("tvalid or fifo read active during reset");

endmodule

bind phy_rx_framer phy_rx_framer_assert u_assert (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .link_up_i    (phy_link_up_i),
  .fifo_empty_i (phy_fifo_empty_i),
  .rd_en_i      (phy_fifo_rd_en_o),
  .tdata_i      (m_axis_tdata_o),
  .tkeep_i      (m_axis_tkeep_o),
  .tvalid_i     (m_axis_tvalid_o),
  .tlast_i      (m_axis_tlast_o),
  .tuser_i      (m_axis_tuser_o),
  .tready_i     (m_axis_tready_i)
);

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held over 8 rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_phy_rx_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "phy_rx_params.svh"

module tb_phy_rx_framer;

  localparam int NUM_FRAMES = 300;

  logic                      clk_i;
  logic                      rst_i;
  logic                      phy_link_up_i;
  logic                      phy_fifo_empty_i;
  logic                      phy_fifo_rd_en_o;
  logic [`PHY_RX_DATA_W-1:0] phy_data_i;
  logic [`PHY_RX_BYTES-1:0]  phy_k_i;
  logic [`PHY_RX_DATA_W-1:0] m_axis_tdata_o;
  logic [`PHY_RX_BYTES-1:0]  m_axis_tkeep_o;
  logic                      m_axis_tvalid_o;
  logic                      m_axis_tlast_o;
  logic [`PHY_RX_USER_W-1:0] m_axis_tuser_o;
  logic                      m_axis_tready_i;

  logic [31:0]            lfsr;
  int                     link_down_left;
  // fifo contents and the beats the reference model expects
  phy_rx_pkg::sym_word_t  fifo_words[$];
  phy_rx_pkg::axis_beat_t exp_beats[$];

  tb_clk_gen u_clk (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  phy_rx_framer u_dut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .phy_link_up_i    (phy_link_up_i),
    .phy_fifo_empty_i (phy_fifo_empty_i),
    .phy_fifo_rd_en_o (phy_fifo_rd_en_o),
    .phy_data_i       (phy_data_i),
    .phy_k_i          (phy_k_i),
    .m_axis_tdata_o   (m_axis_tdata_o),
    .m_axis_tkeep_o   (m_axis_tkeep_o),
    .m_axis_tvalid_o  (m_axis_tvalid_o),
    .m_axis_tlast_o   (m_axis_tlast_o),
    .m_axis_tuser_o   (m_axis_tuser_o),
    .m_axis_tready_i  (m_axis_tready_i)
  );

  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
      abort_run();
    end
  endtask

  // adds idle words and one frame together with its expected beats
  task automatic add_frame();
    logic [8:0]             syms[$];
    logic [7:0]             payload[$];
    logic [31:0]            r;
    logic                   tlp;
    int                     idle;
    int                     len;
    int                     off;
    phy_rx_pkg::sym_word_t  w;
    phy_rx_pkg::axis_beat_t b;
    idle = take_bits(2);
    for (int i = 0; i < idle; i++) begin
      fifo_words.push_back('0);
    end
    tlp = (take_bits(1) != 0);
    len = 1 + take_bits(5) % 24;
    off = take_bits(2);
    for (int i = 0; i < off; i++) begin
      syms.push_back(9'h000);
    end
    // {k, byte}
    syms.push_back({1'b1, tlp ? `PHY_RX_STP : `PHY_RX_SDP});
    for (int i = 0; i < len; i++) begin
      r = take_bits(8);
      payload.push_back(r[7:0]);
      syms.push_back({1'b0, r[7:0]});
    end
    syms.push_back({1'b1, `PHY_RX_END});
    while (syms.size() % `PHY_RX_BYTES != 0) begin
      syms.push_back(9'h000);
    end
    for (int i = 0; i < syms.size(); i += `PHY_RX_BYTES) begin
      for (int j = 0; j < `PHY_RX_BYTES; j++) begin
        w.data[8*j +: 8] = syms[i+j][7:0];
        w.k[j]           = syms[i+j][8];
      end
      fifo_words.push_back(w);
    end
    // four payload bytes per beat with the earliest byte lowest
    for (int i = 0; i < len; i += `PHY_RX_BYTES) begin
      b = '0;
      for (int j = 0; j < `PHY_RX_BYTES && i + j < len; j++) begin
        b.tdata[8*j +: 8] = payload[i+j];
        b.tkeep[j]        = 1'b1;
      end
      b.tlast = (i + `PHY_RX_BYTES >= len);
      b.tuser = tlp ? `PHY_RX_USER_TLP : `PHY_RX_USER_DLLP;
      exp_beats.push_back(b);
    end
  endtask

  task automatic drive_inputs();
    if (link_down_left > 0) begin
      link_down_left--;
    end else if (take_bits(5) == 0) begin
      link_down_left = 1 + take_bits(4);
    end
    phy_link_up_i    = (link_down_left == 0);
    phy_fifo_empty_i = (fifo_words.size() == 0) || (take_bits(2) == 0);
    if (fifo_words.size() != 0) begin
      phy_data_i = fifo_words[0].data;
      phy_k_i    = fifo_words[0].k;
    end
    m_axis_tready_i = (take_bits(2) != 0);
  endtask

  initial begin
    int                     cycles;
    int                     limit;
    int                     words_total;
    int                     reads;
    logic [31:0]            got_data;
    phy_rx_pkg::axis_beat_t want;
    lfsr           = 32'h5787_e7e5;
    link_down_left = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      add_frame();
    end
    words_total = fifo_words.size();
    limit       = 16 * words_total + 1000;
    cycles      = 0;
    reads       = 0;
    // link up with a word waiting while reset is still asserted
    phy_link_up_i    = 1'b1;
    phy_fifo_empty_i = 1'b0;
    phy_data_i       = fifo_words[0].data;
    phy_k_i          = fifo_words[0].k;
    m_axis_tready_i  = 1'b1;

    wait (!rst_i);
    #1;
    check_value("m_axis_tvalid_o", m_axis_tvalid_o, 32'h0);
    check_value("phy_fifo_rd_en_o", phy_fifo_rd_en_o, 32'h0);

    while (fifo_words.size() != 0 || exp_beats.size() != 0) begin
      @(negedge clk_i);
      drive_inputs();
      // values seen here are the ones the next rising edge takes
      #1;
      cycles++;
      if (phy_fifo_rd_en_o) begin
        if (!phy_link_up_i || phy_fifo_empty_i) begin
          $display("fifo read while the link was down or the fifo was empty");
          abort_run();
        end
        void'(fifo_words.pop_front());
        reads++;
      end
      if (m_axis_tvalid_o && m_axis_tready_i) begin
        if (exp_beats.size() == 0) begin
          $display("output beat arrived with no beat expected");
          abort_run();
        end
        want     = exp_beats.pop_front();
        got_data = m_axis_tdata_o;
        // bytes outside tkeep carry no data
        for (int j = 0; j < `PHY_RX_BYTES; j++) begin
          if (!m_axis_tkeep_o[j]) begin
            got_data[8*j +: 8] = 8'h00;
          end
        end
        check_value("m_axis_tdata_o", got_data, want.tdata);
        check_value("m_axis_tkeep_o", m_axis_tkeep_o, want.tkeep);
        check_value("m_axis_tlast_o", m_axis_tlast_o, want.tlast);
        check_value("m_axis_tuser_o", m_axis_tuser_o, want.tuser);
      end
      if (cycles >= limit) begin
        $display("timeout after %0d cycles, %0d beats still expected", cycles,
                 exp_beats.size());
        abort_run();
      end
    end

    // link up and fifo empty, so nothing more comes out and nothing is read
    repeat (32) begin
      @(negedge clk_i);
      phy_link_up_i    = 1'b1;
      phy_fifo_empty_i = 1'b1;
      m_axis_tready_i  = 1'b1;
      #1;
      check_value("m_axis_tvalid_o", m_axis_tvalid_o, 32'h0);
      if (phy_fifo_rd_en_o) begin
        reads++;
      end
    end
    check_value("fifo word reads", reads, words_total);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
phy_rx_pkg.sv
rx_word_capture.sv
frame_detector.sv
byte_packer.sv
axis_skid_buffer.sv
phy_rx_framer.sv
phy_rx_framer_assert.sv
tb_clk_gen.sv
tb_phy_rx_framer.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_phy_rx_framer --Mdir obj_dir
	./obj_dir/Vtb_phy_rx_framer | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir
